// ==== volley_tests.txt ====
// id mask frames ball_x ball_y player_x robot_x score_left score_right, all hex
// mask bit0 left, bit1 right, bit2 jump, bit3 smash; frames 0 checks the reset state
1 0 0  23C 1B  246 3B 0 0
2 0 A  23C 52  246 44 0 0
3 2 1E 232 101 25A 58 0 0
4 1 14 23C ED  232 4E 0 0
5 0 19 23C 160 246 53 0 0
6 0 1A 23C 14B 246 54 0 0
7 8 1C 230 124 246 56 0 0
8 0 46 23C 137 246 78 0 0
9 2 47 1E0 19D 25A 78 1 0

// ==== filelist.f ====
volley_pkg.sv
step_sequencer.sv
player_ctrl.sv
robot_ctrl.sv
ball_physics.sv
contact_detect.sv
score_keeper.sv
volley_top.sv
volley_assert.sv
tb_volley.sv

// ==== Bender.yml ====
package:
  name: volley

sources:
  - volley_pkg.sv
  - step_sequencer.sv
  - player_ctrl.sv
  - robot_ctrl.sv
  - ball_physics.sv
  - contact_detect.sv
  - score_keeper.sv
  - volley_top.sv
  - target: simulation
    files:
      - volley_assert.sv
      - tb_volley.sv

// ==== tb_volley.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_volley import volley_pkg::*; ();

  // each test line holds nine fields, see volley_tests.txt
  localparam int NUM_FIELDS = 9;
  localparam int MAX_TESTS  = 32;
  localparam int WAIT_LIMIT = 4 * FRAME_CYCLES;

  logic   clk;
  logic   reset_n;
  logic   btn_left;
  logic   btn_right;
  logic   btn_jump;
  logic   btn_smash;
  pos_t   ball_x;
  pos_t   ball_y;
  pos_t   player_x;
  pos_t   player_y;
  pos_t   robot_x;
  score_t score_left;
  score_t score_right;
  logic   frame;
  logic   serving;

  logic [15:0] vectors [NUM_FIELDS*MAX_TESTS];
  integer      seed;
  int          test_id;

  volley_top u_dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .btn_left_i    (btn_left),
    .btn_right_i   (btn_right),
    .btn_jump_i    (btn_jump),
    .btn_smash_i   (btn_smash),
    .ball_x_o      (ball_x),
    .ball_y_o      (ball_y),
    .player_x_o    (player_x),
    .player_y_o    (player_y),
    .robot_x_o     (robot_x),
    .score_left_o  (score_left),
    .score_right_o (score_right),
    .frame_o       (frame),
    .serving_o     (serving)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ----------------------------------------------------------------------
  // error reporting
  task automatic end_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input int got, input int expected);
    $display("Fail at %0t ns: test %0d, %s is %0d, expected %0d",
             $time, test_id, name, got, expected);
    end_with_failure();
  endtask

  task automatic report_problem(input string what);
    $display("Test %0d went wrong: %s", test_id, what);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input int got, input int expected);
    assert (got == expected) else report_mismatch(name, got, expected);
  endtask

  // the bound checker counts its own assertion failures
  always @(negedge clk) begin
    assert (u_dut.u_assert.fail_count == 0)
      else report_problem("a bound assertion on volley_top failed");
  end

  // ----------------------------------------------------------------------
  // player height after some frames from serve, jump held or not
  function automatic int player_y_after(input logic jump, input int frames);
    int y;
    int vy;
    y  = int'(PLAYER_GROUND_Y);
    vy = 0;
    for (int f = 0; f < frames; f++) begin
      if (y == int'(PLAYER_GROUND_Y)) begin
        vy = jump ? int'(JUMP_VEL) : 0;
      end else if (vy > -int'(JUMP_VEL)) begin
        vy = vy - 1;
      end
      y = y - vy;
      if (y > int'(PLAYER_GROUND_Y)) begin
        y = int'(PLAYER_GROUND_Y);
      end
    end
    return y;
  endfunction

  // ----------------------------------------------------------------------
  // stimulus, driven just after the rising edge
  task automatic set_buttons(input logic [3:0] mask);
    @(posedge clk);
    #1;
    btn_left  = mask[0];
    btn_right = mask[1];
    btn_jump  = mask[2];
    btn_smash = mask[3];
  endtask

  task automatic apply_reset(input logic [3:0] mask);
    set_buttons(mask);
    reset_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;
  endtask

  task automatic count_serve_cycles();
    int cycles;
    int guard;
    cycles = 0;
    guard  = 0;
    @(negedge clk);
    while (serving && guard < WAIT_LIMIT) begin
      cycles++;
      guard++;
      @(negedge clk);
    end
    assert (!serving) else report_problem("timeout while waiting for the serve to end");
    check_value("serve length", cycles, SERVE_CYCLES);
  endtask

  // counts frame pulses, every frame inside a round lasts FRAME_CYCLES
  task automatic wait_frames(input int count);
    int seen;
    int guard;
    int gap;
    seen  = 0;
    guard = 0;
    gap   = 0;
    while (seen < count) begin
      @(negedge clk);
      guard++;
      gap++;
      if (frame) begin
        if (seen > 0) begin
          check_value("frame length", gap, FRAME_CYCLES);
        end
        seen++;
        gap   = 0;
        guard = 0;
      end
      assert (guard < WAIT_LIMIT) else report_problem("timeout while waiting for frame_o");
    end
  endtask

  task automatic check_serve_return(input int left, input int right);
    int guard;
    guard = 0;
    while (!serving && guard < WAIT_LIMIT) begin
      @(negedge clk);
      guard++;
    end
    assert (serving) else report_problem("serving_o did not rise after the point");
    // positions reload on the first serve cycle
    @(negedge clk);
    check_value("serve ball_x", ball_x, BALL_SERVE_X);
    check_value("serve ball_y", ball_y, BALL_SERVE_Y);
    check_value("serve player_x", player_x, PLAYER_SERVE_X);
    check_value("serve robot_x", robot_x, ROBOT_SERVE_X);
    check_value("held score_left", score_left, left);
    check_value("held score_right", score_right, right);
  endtask

  // ----------------------------------------------------------------------
  task automatic run_test(input int base);
    logic [3:0] mask;
    int         frames;
    int         fill;
    test_id = vectors[base];
    mask    = vectors[base+1][3:0];
    frames  = vectors[base+2];
    apply_reset(mask);
    if (frames == 0) begin
      @(negedge clk);
      assert (serving) else report_problem("serving_o low right after reset");
    end else begin
      count_serve_cycles();
      wait_frames(frames);
      // scores settle one cycle after the frame pulse
      @(negedge clk);
    end
    check_value("ball_x", ball_x, vectors[base+3]);
    check_value("ball_y", ball_y, vectors[base+4]);
    check_value("player_x", player_x, vectors[base+5]);
    check_value("player_y", player_y, player_y_after(mask[2], frames));
    check_value("robot_x", robot_x, vectors[base+6]);
    check_value("score_left", score_left, vectors[base+7]);
    check_value("score_right", score_right, vectors[base+8]);
    if (vectors[base+7] + vectors[base+8] != 0) begin
      check_serve_return(vectors[base+7], vectors[base+8]);
    end
    // a few idle frames with the buttons released
    fill = {$random(seed)} % 3;
    set_buttons(4'b0000);
    wait_frames(fill);
  endtask

  initial begin
    int t;
    reset_n   = 1'b0;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_jump  = 1'b0;
    btn_smash = 1'b0;
    seed      = 81862;
    test_id   = 0;
    $readmemh("volley_tests.txt", vectors);
    assert (vectors[0] != 0 && !$isunknown(vectors[0]))
      else report_problem("no test vectors could be read");
    t = 0;
    while (t < MAX_TESTS && vectors[t*NUM_FIELDS] != 0 && !$isunknown(vectors[t*NUM_FIELDS])) begin
      run_test(t * NUM_FIELDS);
      t++;
    end
    if (u_dut.u_assert.fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      report_problem("a bound assertion on volley_top failed");
    end
  end

endmodule

`default_nettype wire

// ==== volley_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module volley_assert import volley_pkg::*; (
  input logic   clk,
  input logic   reset_n,
  input logic   frame_i,
  input logic   serving_i,
  input pos_t   ball_y_i,
  input pos_t   player_x_i,
  input score_t score_left_i,
  input score_t score_right_i
);

  // number of assertion failures so far
  int fail_count = 0;

  // positions are only final while the frame pulse is high
  a_ball_y: assert property (@(posedge clk) disable iff (!reset_n)
    frame_i |-> (ball_y_i >= BALL_MIN) && (ball_y_i <= BALL_MAX_Y))
    else begin
      fail_count++;
      $error("ball_y left the court at the end of a frame");
    end

  a_player_x: assert property (@(posedge clk) disable iff (!reset_n)
    frame_i |-> (player_x_i >= PLAYER_MIN_X) && (player_x_i <= PLAYER_MAX_X))
    else begin
      fail_count++;
      $error("player_x left its half at the end of a frame");
    end

  a_no_frame_in_serve: assert property (@(posedge clk) disable iff (!reset_n)
    !(frame_i && serving_i))
    else begin
      fail_count++;
      $error("frame pulse during the serve wait");
    end

  a_score_timing: assert property (@(posedge clk) disable iff (!reset_n)
    (!$stable(score_left_i) || !$stable(score_right_i)) |-> $past(frame_i))
    else begin
      fail_count++;
      $error("score changed outside the cycle after a frame pulse");
    end

endmodule

bind volley_top volley_assert u_assert (
  .clk           (clk),
  .reset_n       (reset_n),
  .frame_i       (frame_o),
  .serving_i     (serving_o),
  .ball_y_i      (ball_y_o),
  .player_x_i    (player_x_o),
  .score_left_i  (score_left_o),
  .score_right_i (score_right_o)
);

`default_nettype wire

// ==== volley_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module volley_top import volley_pkg::*; (
  input  logic   clk,
  input  logic   reset_n,
  input  logic   btn_left_i,
  input  logic   btn_right_i,
  input  logic   btn_jump_i,
  input  logic   btn_smash_i,
  output pos_t   ball_x_o,
  output pos_t   ball_y_o,
  output pos_t   player_x_o,
  output pos_t   player_y_o,
  output pos_t   robot_x_o,
  output score_t score_left_o,
  output score_t score_right_o,
  output logic   frame_o,
  output logic   serving_o
);

  step_e step;
  logic  round_over;
  zone_e player_zone;
  zone_e robot_zone;

  // ----------------------------------------------------------------------
  // frame control
  step_sequencer u_seq (
    .clk          (clk),
    .reset_n      (reset_n),
    .round_over_i (round_over),
    .step_o       (step),
    .frame_o      (frame_o),
    .serving_o    (serving_o)
  );

  // ----------------------------------------------------------------------
  // bodies
  player_ctrl u_player (
    .clk         (clk),
    .reset_n     (reset_n),
    .step_i      (step),
    .btn_left_i  (btn_left_i),
    .btn_right_i (btn_right_i),
    .btn_jump_i  (btn_jump_i),
    .player_x_o  (player_x_o),
    .player_y_o  (player_y_o)
  );

  robot_ctrl u_robot (
    .clk       (clk),
    .reset_n   (reset_n),
    .step_i    (step),
    .ball_x_i  (ball_x_o),
    .robot_x_o (robot_x_o)
  );

  ball_physics u_ball (
    .clk           (clk),
    .reset_n       (reset_n),
    .step_i        (step),
    .btn_smash_i   (btn_smash_i),
    .player_zone_i (player_zone),
    .robot_zone_i  (robot_zone),
    .ball_x_o      (ball_x_o),
    .ball_y_o      (ball_y_o)
  );

  // ----------------------------------------------------------------------
  // contact and scoring
  contact_detect u_contact (
    .clk           (clk),
    .step_i        (step),
    .ball_x_i      (ball_x_o),
    .ball_y_i      (ball_y_o),
    .player_x_i    (player_x_o),
    .player_y_i    (player_y_o),
    .robot_x_i     (robot_x_o),
    .player_zone_o (player_zone),
    .robot_zone_o  (robot_zone)
  );

  score_keeper u_score (
    .clk           (clk),
    .reset_n       (reset_n),
    .step_i        (step),
    .ball_x_i      (ball_x_o),
    .ball_y_i      (ball_y_o),
    .score_left_o  (score_left_o),
    .score_right_o (score_right_o),
    .round_over_o  (round_over)
  );

endmodule

`default_nettype wire

// ==== score_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_keeper import volley_pkg::*; (
  input  logic   clk,
  input  logic   reset_n,
  input  step_e  step_i,
  input  pos_t   ball_x_i,
  input  pos_t   ball_y_i,
  output score_t score_left_o,
  output score_t score_right_o,
  output logic   round_over_o
);

  score_t score_left_q;
  score_t score_right_q;
  logic   robot_d;
  logic   first_idle;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      score_left_q  <= '0;
      score_right_q <= '0;
      robot_d       <= 1'b0;
    end else begin
      robot_d <= (step_i == STEP_ROBOT);
      if (round_over_o) begin
        // a landing on the right half is a point for the robot
        if (ball_x_i > MID_X) begin
          score_left_q <= score_left_q + 1'b1;
        end else begin
          score_right_q <= score_right_q + 1'b1;
        end
      end
    end
  end

  assign first_idle    = (step_i == STEP_IDLE) && robot_d;
  assign round_over_o  = first_idle && (ball_y_i > GROUND_Y);
  assign score_left_o  = score_left_q;
  assign score_right_o = score_right_q;

endmodule

`default_nettype wire

// ==== contact_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module contact_detect import volley_pkg::*; (
  input  logic  clk,
  input  step_e step_i,
  input  pos_t  ball_x_i,
  input  pos_t  ball_y_i,
  input  pos_t  player_x_i,
  input  pos_t  player_y_i,
  input  pos_t  robot_x_i,
  output zone_e player_zone_o,
  output zone_e robot_zone_o
);

  // index 0 is the player, index 1 the robot
  pos_t               body_x [2];
  pos_t               body_y [2];
  logic signed [10:0] dx_q   [2];
  logic signed [10:0] dy_q   [2];
  logic [21:0]        sqx_q  [2];
  logic [21:0]        sqy_q  [2];
  logic [22:0]        sum_q  [2];

  assign body_x[0] = player_x_i;
  assign body_y[0] = player_y_i;
  assign body_x[1] = robot_x_i;
  assign body_y[1] = ROBOT_Y;

  // one pipeline stage per distance step
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (step_i == STEP_DIST0) begin
        dx_q[i] <= $signed({1'b0, ball_x_i}) - $signed({1'b0, body_x[i]});
        dy_q[i] <= $signed({1'b0, ball_y_i}) - $signed({1'b0, body_y[i]});
      end
      if (step_i == STEP_DIST1) begin
        sqx_q[i] <= dx_q[i] * dx_q[i];
        sqy_q[i] <= dy_q[i] * dy_q[i];
      end
      if (step_i == STEP_DIST2) begin
        sum_q[i] <= sqx_q[i] + sqy_q[i];
      end
    end
  end

  // zones read the stage 2 sums, valid from STEP_HIT on
  always_comb begin
    if (sum_q[0] > CONTACT_R2) begin
      player_zone_o = ZONE_NONE;
    end else if (dx_q[0] >= FRONT_DX) begin
      player_zone_o = ZONE_FRONT;
    end else if (dx_q[0] <= BACK_DX) begin
      player_zone_o = ZONE_BACK;
    end else begin
      player_zone_o = ZONE_CENTER;
    end
    if (sum_q[1] > CONTACT_R2) begin
      robot_zone_o = ZONE_NONE;
    end else begin
      robot_zone_o = (dx_q[1] >= 0) ? ZONE_FRONT : ZONE_BACK;
    end
  end

endmodule

`default_nettype wire

// ==== ball_physics.sv ====
`timescale 1ns/1ps
`default_nettype none

module ball_physics import volley_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  step_e step_i,
  input  logic  btn_smash_i,
  input  zone_e player_zone_i,
  input  zone_e robot_zone_i,
  output pos_t  ball_x_o,
  output pos_t  ball_y_o
);

  pos_t x_q;
  pos_t y_q;
  vel_t vel_x;
  vel_t vel_y;
  logic in_net;
  logic toward_net;

  assign in_net = (x_q >= NET_LO_X) && (x_q <= NET_HI_X) && (y_q > NET_TOP_Y);

  // only bounce off the net when moving into it, so the ball can leave
  assign toward_net = (x_q < HALF_X) ? (vel_x > 0) : (vel_x < 0);

  always_ff @(posedge clk) begin
    if (!reset_n || step_i == STEP_SERVE) begin
      x_q   <= BALL_SERVE_X;
      y_q   <= BALL_SERVE_Y;
      vel_x <= '0;
      vel_y <= '0;
    end else begin
      case (step_i)
        STEP_VELOCITY: vel_y <= vel_y - GRAVITY;
        STEP_MOVE: begin
          x_q <= pos_add(x_q, vel_x);
          y_q <= pos_sub(y_q, vel_y);
        end
        // ------------------------------------------------------------------
        // court clamp and rebounds
        STEP_CLAMP: begin
          if (x_q > BALL_MAX_X) begin
            x_q   <= BALL_MAX_X;
            vel_x <= -vel_x;
          end else if (x_q < BALL_MIN) begin
            x_q   <= BALL_MIN;
            vel_x <= -vel_x;
          end else if (in_net && toward_net) begin
            vel_x <= -vel_x;
          end
          if (y_q > BALL_MAX_Y) begin
            y_q   <= BALL_MAX_Y;
            vel_y <= -vel_y;
          end else if (y_q < BALL_MIN) begin
            y_q   <= BALL_MIN;
            vel_y <= -vel_y;
          end else if (in_net && vel_y < 0) begin
            // falling onto the net top
            vel_y <= -vel_y;
          end
        end
        // ------------------------------------------------------------------
        // hit response, robot contact overrides the player
        STEP_HIT: begin
          if (robot_zone_i == ZONE_FRONT) begin
            vel_y <= HIT_VEL;
            vel_x <= DEFLECT_X_VEL;
          end else if (robot_zone_i == ZONE_BACK) begin
            vel_y <= HIT_VEL;
            vel_x <= -DEFLECT_X_VEL;
          end else begin
            case (player_zone_i)
              ZONE_CENTER: begin
                vel_y <= HIT_VEL;
                vel_x <= btn_smash_i ? SMASH_X_VEL : '0;
              end
              ZONE_FRONT: begin
                vel_y <= btn_smash_i ? SMASH_DOWN_VEL : HIT_VEL;
                vel_x <= btn_smash_i ? SMASH_X_VEL : DEFLECT_X_VEL;
              end
              ZONE_BACK: begin
                vel_y <= btn_smash_i ? SMASH_DOWN_VEL : HIT_VEL;
                vel_x <= btn_smash_i ? SMASH_X_VEL : -DEFLECT_X_VEL;
              end
              default: ;
            endcase
          end
        end
        default: ;
      endcase
    end
  end

  assign ball_x_o = x_q;
  assign ball_y_o = y_q;

endmodule

`default_nettype wire

// ==== robot_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module robot_ctrl import volley_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  step_e step_i,
  input  pos_t  ball_x_i,
  output pos_t  robot_x_o
);

  pos_t x_q;
  vel_t vel_x;
  pos_t target_x;

  // chase the ball on our side, otherwise walk back home
  assign target_x = (ball_x_i < HALF_X) ? ball_x_i : ROBOT_HOME_X;

  always_ff @(posedge clk) begin
    if (!reset_n || step_i == STEP_SERVE) begin
      x_q   <= ROBOT_SERVE_X;
      vel_x <= '0;
    end else begin
      case (step_i)
        STEP_ROBOT: begin
          if (target_x > x_q) begin
            vel_x <= 8'sd1;
          end else if (target_x < x_q) begin
            vel_x <= -8'sd1;
          end else begin
            vel_x <= '0;
          end
        end
        STEP_MOVE: x_q <= pos_add(x_q, vel_x);
        STEP_CLAMP: begin
          if (x_q > ROBOT_MAX_X) begin
            x_q <= ROBOT_MAX_X;
          end else if (x_q < ROBOT_MIN_X) begin
            x_q <= ROBOT_MIN_X;
          end
        end
        default: ;
      endcase
    end
  end

  assign robot_x_o = x_q;

endmodule

`default_nettype wire

// ==== player_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_ctrl import volley_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  step_e step_i,
  input  logic  btn_left_i,
  input  logic  btn_right_i,
  input  logic  btn_jump_i,
  output pos_t  player_x_o,
  output pos_t  player_y_o
);

  pos_t x_q;
  pos_t y_q;
  vel_t vel_x;
  vel_t vel_y;
  logic on_ground;

  assign on_ground = (y_q == PLAYER_GROUND_Y);

  always_ff @(posedge clk) begin
    if (!reset_n || step_i == STEP_SERVE) begin
      x_q   <= PLAYER_SERVE_X;
      y_q   <= PLAYER_GROUND_Y;
      vel_x <= '0;
      vel_y <= '0;
    end else begin
      case (step_i)
        STEP_VELOCITY: begin
          // right wins when both are held
          if (btn_right_i) begin
            vel_x <= 8'sd1;
          end else if (btn_left_i) begin
            vel_x <= -8'sd1;
          end else begin
            vel_x <= '0;
          end
          if (on_ground) begin
            vel_y <= btn_jump_i ? JUMP_VEL : '0;
          end else if (vel_y > -JUMP_VEL) begin
            vel_y <= vel_y - GRAVITY;
          end
        end
        STEP_MOVE: begin
          x_q <= pos_add(x_q, vel_x);
          y_q <= pos_sub(y_q, vel_y);
        end
        STEP_CLAMP: begin
          // keep to the right half of the court
          if (x_q > PLAYER_MAX_X) begin
            x_q <= PLAYER_MAX_X;
          end else if (x_q < PLAYER_MIN_X) begin
            x_q <= PLAYER_MIN_X;
          end
          if (y_q > PLAYER_GROUND_Y) begin
            y_q <= PLAYER_GROUND_Y;
          end
        end
        default: ;
      endcase
    end
  end

  assign player_x_o = x_q;
  assign player_y_o = y_q;

endmodule

`default_nettype wire

// ==== step_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_sequencer import volley_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  round_over_i,
  output step_e step_o,
  output logic  frame_o,
  output logic  serving_o
);

  step_e                           step_q;
  logic [$clog2(SERVE_CYCLES)-1:0] serve_cnt;
  logic [$clog2(FRAME_CYCLES)-1:0] frame_cnt;
  logic                            round_pend;
  logic                            frame_q;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      step_q     <= STEP_SERVE;
      serve_cnt  <= '0;
      frame_cnt  <= '0;
      round_pend <= 1'b0;
      frame_q    <= 1'b0;
    end else begin
      // the step after STEP_ROBOT is always the first idle cycle
      frame_q <= (step_q == STEP_ROBOT);
      case (step_q)
        STEP_SERVE: begin
          frame_cnt  <= '0;
          round_pend <= 1'b0;
          if (serve_cnt == SERVE_CYCLES - 1) begin
            serve_cnt <= '0;
            step_q    <= STEP_VELOCITY;
          end else begin
            serve_cnt <= serve_cnt + 1'b1;
          end
        end
        STEP_IDLE: begin
          if (round_over_i) begin
            round_pend <= 1'b1;
          end
          // wait out the rest of the frame
          if (frame_cnt == FRAME_CYCLES - 1) begin
            frame_cnt <= '0;
            step_q    <= (round_pend || round_over_i) ? STEP_SERVE : STEP_VELOCITY;
          end else begin
            frame_cnt <= frame_cnt + 1'b1;
          end
        end
        default: begin
          // single-cycle steps run in enum order
          frame_cnt <= frame_cnt + 1'b1;
          step_q    <= step_e'(step_q + 1'b1);
        end
      endcase
    end
  end

  assign step_o    = step_q;
  assign frame_o   = frame_q;
  assign serving_o = (step_q == STEP_SERVE);

endmodule

`default_nettype wire

// ==== volley_pkg.sv ====
`default_nettype none

package volley_pkg;

  typedef logic [9:0] pos_t;
  typedef logic signed [7:0] vel_t;
  typedef logic [3:0] score_t;

  typedef enum logic [3:0] {
    STEP_SERVE,
    STEP_VELOCITY,
    STEP_MOVE,
    STEP_CLAMP,
    STEP_DIST0,
    STEP_DIST1,
    STEP_DIST2,
    STEP_HIT,
    STEP_ROBOT,
    STEP_IDLE
  } step_e;

  typedef enum logic [1:0] {
    ZONE_NONE,
    ZONE_FRONT,
    ZONE_CENTER,
    ZONE_BACK
  } zone_e;

  // frame pacing, kept short for simulation
  localparam int SERVE_CYCLES = 40;
  localparam int FRAME_CYCLES = 200;

  // ----------------------------------------------------------------------
  // court geometry
  localparam pos_t GROUND_Y        = 10'd410;
  localparam pos_t PLAYER_GROUND_Y = 10'd401;
  localparam pos_t BALL_MIN        = 10'd27;
  localparam pos_t BALL_MAX_X      = 10'd613;
  localparam pos_t BALL_MAX_Y      = 10'd413;
  localparam pos_t NET_LO_X        = 10'd290;
  localparam pos_t NET_HI_X        = 10'd350;
  localparam pos_t NET_TOP_Y       = 10'd250;
  localparam pos_t MID_X           = 10'd330;
  localparam pos_t PLAYER_MIN_X    = 10'd361;
  localparam pos_t PLAYER_MAX_X    = 10'd602;
  localparam pos_t ROBOT_MIN_X     = 10'd39;
  localparam pos_t ROBOT_MAX_X     = 10'd281;
  localparam pos_t ROBOT_HOME_X    = 10'd120;
  localparam pos_t HALF_X          = 10'd320;

  // serve positions
  localparam pos_t PLAYER_SERVE_X = 10'd582;
  localparam pos_t ROBOT_SERVE_X  = 10'd59;
  localparam pos_t ROBOT_Y        = 10'd401;
  localparam pos_t BALL_SERVE_X   = 10'd572;
  localparam pos_t BALL_SERVE_Y   = 10'd27;

  // ----------------------------------------------------------------------
  // physics, velocities in pixels per frame
  localparam vel_t GRAVITY        = 8'sd1;
  localparam vel_t JUMP_VEL       = 8'sd21;
  localparam vel_t HIT_VEL        = 8'sd22;
  localparam vel_t SMASH_DOWN_VEL = -8'sd18;
  localparam vel_t SMASH_X_VEL    = -8'sd4;
  localparam vel_t DEFLECT_X_VEL  = 8'sd2;
  localparam int   CONTACT_R2     = 3600;
  localparam int   FRONT_DX       = 20;
  localparam int   BACK_DX        = -30;

  // position plus signed velocity, wraps in 10 bits
  function automatic pos_t pos_add(pos_t p, vel_t v);
    return p + {{2{v[7]}}, v};
  endfunction

  // y grows downward, so upward velocity is subtracted
  function automatic pos_t pos_sub(pos_t p, vel_t v);
    return p - {{2{v[7]}}, v};
  endfunction

endpackage

`default_nettype wire
